//--- sensor_pkg.sv
`default_nettype none

package sensor_pkg;

	localparam int PIXEL_BITS = 8;
	localparam int RAMP_STEPS = 2 ** PIXEL_BITS; // One convert step per code.

	typedef logic [PIXEL_BITS-1:0] pixel_t;

	function automatic pixel_t to_gray(input pixel_t bin);
		return bin ^ (bin >> 1);
	endfunction

	function automatic pixel_t from_gray(input pixel_t gray);
		pixel_t bin;
		bin[PIXEL_BITS-1] = gray[PIXEL_BITS-1];
		for (int i = PIXEL_BITS - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i]; // Running XOR from the MSB down.
		end
		return bin;
	endfunction

endpackage

`default_nettype wire

//--- phase_pkg.sv
`default_nettype none

package phase_pkg;

	typedef enum logic [2:0] {
		phase_idle,
		phase_erase,
		phase_expose,
		phase_convert,
		phase_read
	} phase_t;

	localparam int DEFAULT_ERASE_CYCLES = 5;
	localparam int DEFAULT_EXPOSE_CYCLES = 16;
	localparam int DEFAULT_ROW_READ_CYCLES = 5; // Per row.

endpackage

`default_nettype wire

//--- frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer import phase_pkg::*, sensor_pkg::*; #(
	parameter int PIXEL_ROWS = 3,
	parameter int ERASE_CYCLES = DEFAULT_ERASE_CYCLES,
	parameter int EXPOSE_CYCLES = DEFAULT_EXPOSE_CYCLES,
	parameter int ROW_READ_CYCLES = DEFAULT_ROW_READ_CYCLES
) (
	input wire clk,
	input wire reset,
	output logic erase,
	output logic expose,
	output logic convert,
	output pixel_t ramp_count,
	output pixel_t ramp_gray,
	output logic [PIXEL_ROWS-1:0] row_select,
	output logic row_strobe,
	output logic frame_done
);

	localparam int CNT_BITS = $clog2(ERASE_CYCLES + EXPOSE_CYCLES + RAMP_STEPS + ROW_READ_CYCLES);
	localparam int ROW_BITS = (PIXEL_ROWS > 1) ? $clog2(PIXEL_ROWS) : 1;

	phase_t phase;
	phase_t phase_next;
	logic [CNT_BITS-1:0] cycle_count;
	logic [CNT_BITS-1:0] phase_len;
	logic [ROW_BITS-1:0] row_count;
	logic last_cycle;
	logic last_row;
	pixel_t ramp_next;

	always_comb begin
		case (phase)
			phase_idle: phase_len = CNT_BITS'(1);
			phase_erase: phase_len = CNT_BITS'(ERASE_CYCLES);
			phase_expose: phase_len = CNT_BITS'(EXPOSE_CYCLES);
			phase_convert: phase_len = CNT_BITS'(RAMP_STEPS);
			default: phase_len = CNT_BITS'(ROW_READ_CYCLES); // One row slot.
		endcase
	end

	assign last_cycle = (cycle_count == phase_len - 1'b1);
	assign last_row = (row_count == ROW_BITS'(PIXEL_ROWS - 1));

	always_comb begin
		phase_next = phase;
		if (last_cycle) begin
			case (phase)
				phase_idle: phase_next = phase_erase;
				phase_erase: phase_next = phase_expose;
				phase_expose: phase_next = phase_convert;
				phase_convert: phase_next = phase_read;
				phase_read: begin
					if (last_row) begin
						phase_next = phase_idle; // Frame wraps around.
					end
				end
				default: phase_next = phase_idle;
			endcase
		end
	end

	assign ramp_next = (phase == phase_convert) ? ramp_count + 1'b1 : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= phase_idle;
			cycle_count <= '0;
			row_count <= '0;
			ramp_count <= '0;
			ramp_gray <= '0;
		end else begin
			phase <= phase_next;
			ramp_count <= ramp_next;
			ramp_gray <= to_gray(ramp_next); // Same edge as the binary ramp.
			if (last_cycle) begin
				cycle_count <= '0;
			end else begin
				cycle_count <= cycle_count + 1'b1;
			end
			if (phase == phase_read && last_cycle) begin
				row_count <= last_row ? '0 : row_count + 1'b1;
			end
		end
	end

	assign erase = (phase == phase_erase);
	assign expose = (phase == phase_expose);
	assign convert = (phase == phase_convert);
	assign row_select = (phase == phase_read) ? (PIXEL_ROWS'(1) << row_count) : '0;
	assign row_strobe = (phase == phase_read) && (cycle_count == CNT_BITS'(1)); // Bus settled.
	assign frame_done = (phase == phase_read) && last_cycle && last_row;

endmodule

`default_nettype wire

//--- pixel_cell.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_cell import sensor_pkg::*; (
	input wire clk,
	input wire reset,
	input wire erase,
	input wire expose,
	input wire convert,
	input wire pixel_t light,
	input wire pixel_t ramp_count,
	input wire pixel_t ramp_gray,
	output pixel_t level
);

	pixel_t threshold;
	logic tripped;

	always_ff @(posedge clk) begin
		if (expose) begin
			threshold <= pixel_t'(RAMP_STEPS - 1) - light; // Bright pixels trip early.
		end
	end

	// Comparator fires once per frame, at the matching ramp step.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tripped <= 1'b0;
			level <= '0;
		end else if (erase) begin
			tripped <= 1'b0;
			level <= '0;
		end else if (convert && !tripped && ramp_count == threshold) begin
			tripped <= 1'b1;
			level <= ramp_gray;
		end
	end

endmodule

`default_nettype wire

//--- pixel_array.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_array import sensor_pkg::*; #(
	parameter int PIXEL_COLS = 24,
	parameter int PIXEL_ROWS = 3
) (
	input wire clk,
	input wire reset,
	input wire erase,
	input wire expose,
	input wire convert,
	input wire pixel_t ramp_count,
	input wire pixel_t ramp_gray,
	input wire [PIXEL_ROWS*PIXEL_COLS*PIXEL_BITS-1:0] light,
	input wire [PIXEL_ROWS-1:0] row_select,
	output logic [PIXEL_COLS*PIXEL_BITS-1:0] column_bus
);

	localparam int ROW_BITS = PIXEL_COLS * PIXEL_BITS;

	wire [PIXEL_ROWS*ROW_BITS-1:0] levels;

	for (genvar r = 0; r < PIXEL_ROWS; r++) begin : g_row
		for (genvar c = 0; c < PIXEL_COLS; c++) begin : g_col
			localparam int IDX = r * PIXEL_COLS + c;
			pixel_cell u_cell (
				.clk(clk),
				.reset(reset),
				.erase(erase),
				.expose(expose),
				.convert(convert),
				.light(light[IDX*PIXEL_BITS +: PIXEL_BITS]),
				.ramp_count(ramp_count),
				.ramp_gray(ramp_gray),
				.level(levels[IDX*PIXEL_BITS +: PIXEL_BITS])
			);
		end
	end

	// One-hot row select makes the OR a plain mux.
	always_comb begin
		column_bus = '0;
		for (int r = 0; r < PIXEL_ROWS; r++) begin
			column_bus = column_bus | (levels[r*ROW_BITS +: ROW_BITS] & {ROW_BITS{row_select[r]}});
		end
	end

endmodule

`default_nettype wire

//--- row_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module row_serializer import sensor_pkg::*; #(
	parameter int PIXEL_COLS = 24,
	parameter int BUS_PIXELS = 8
) (
	input wire clk,
	input wire reset,
	input wire row_strobe,
	input wire [PIXEL_COLS*PIXEL_BITS-1:0] column_bus,
	output logic [BUS_PIXELS*PIXEL_BITS-1:0] data_out,
	output logic out_valid
);

	localparam int BEATS = PIXEL_COLS / BUS_PIXELS;
	localparam int BEAT_W = BUS_PIXELS * PIXEL_BITS;
	localparam int ROW_W = PIXEL_COLS * PIXEL_BITS;
	localparam int COUNT_BITS = $clog2(BEATS + 1);

	logic [ROW_W-1:0] decoded;
	logic [ROW_W-1:0] row_data;
	logic [COUNT_BITS-1:0] beats_left;

	always_comb begin
		for (int c = 0; c < PIXEL_COLS; c++) begin
			decoded[c*PIXEL_BITS +: PIXEL_BITS] = from_gray(column_bus[c*PIXEL_BITS +: PIXEL_BITS]);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			beats_left <= '0;
		end else if (row_strobe) begin
			beats_left <= COUNT_BITS'(BEATS);
		end else if (beats_left != '0) begin
			beats_left <= beats_left - 1'b1;
		end
	end

	// Lowest columns leave first.
	always_ff @(posedge clk) begin
		if (row_strobe) begin
			row_data <= decoded;
		end else if (out_valid) begin
			row_data <= row_data >> BEAT_W;
		end
	end

	assign out_valid = (beats_left != '0);
	assign data_out = out_valid ? row_data[BEAT_W-1:0] : '0;

endmodule

`default_nettype wire

//--- image_sensor.sv
`timescale 1ns/100ps
`default_nettype none

module image_sensor import phase_pkg::*, sensor_pkg::*; #(
	parameter int PIXEL_COLS = 24,
	parameter int PIXEL_ROWS = 3,
	parameter int BUS_PIXELS = 8,
	parameter int ERASE_CYCLES = DEFAULT_ERASE_CYCLES,
	parameter int EXPOSE_CYCLES = DEFAULT_EXPOSE_CYCLES,
	parameter int ROW_READ_CYCLES = DEFAULT_ROW_READ_CYCLES
) (
	input wire clk,
	input wire reset,
	input wire [PIXEL_ROWS*PIXEL_COLS*PIXEL_BITS-1:0] light,
	output wire [BUS_PIXELS*PIXEL_BITS-1:0] data_out,
	output wire out_valid,
	output wire frame_done
);

	wire erase;
	wire expose;
	wire convert;
	wire pixel_t ramp_count;
	wire pixel_t ramp_gray;
	wire [PIXEL_ROWS-1:0] row_select;
	wire row_strobe;
	wire [PIXEL_COLS*PIXEL_BITS-1:0] column_bus;

	if (PIXEL_COLS % BUS_PIXELS != 0) begin : g_bad_beat
		$error("PIXEL_COLS must be a multiple of BUS_PIXELS");
	end
	if (ROW_READ_CYCLES < PIXEL_COLS / BUS_PIXELS + 2) begin : g_bad_slot
		$error("ROW_READ_CYCLES too short for one row");
	end

	frame_sequencer #(
		.PIXEL_ROWS(PIXEL_ROWS),
		.ERASE_CYCLES(ERASE_CYCLES),
		.EXPOSE_CYCLES(EXPOSE_CYCLES),
		.ROW_READ_CYCLES(ROW_READ_CYCLES)
	) u_sequencer (
		.clk(clk),
		.reset(reset),
		.erase(erase),
		.expose(expose),
		.convert(convert),
		.ramp_count(ramp_count),
		.ramp_gray(ramp_gray),
		.row_select(row_select),
		.row_strobe(row_strobe),
		.frame_done(frame_done)
	);

	pixel_array #(
		.PIXEL_COLS(PIXEL_COLS),
		.PIXEL_ROWS(PIXEL_ROWS)
	) u_array (
		.clk(clk),
		.reset(reset),
		.erase(erase),
		.expose(expose),
		.convert(convert),
		.ramp_count(ramp_count),
		.ramp_gray(ramp_gray),
		.light(light),
		.row_select(row_select),
		.column_bus(column_bus)
	);

	row_serializer #(
		.PIXEL_COLS(PIXEL_COLS),
		.BUS_PIXELS(BUS_PIXELS)
	) u_serializer (
		.clk(clk),
		.reset(reset),
		.row_strobe(row_strobe),
		.column_bus(column_bus),
		.data_out(data_out),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

//--- image_sensor_chk.sv
`timescale 1ns/100ps
`default_nettype none

module image_sensor_chk import phase_pkg::*; #(
	parameter int PIXEL_ROWS = 3
) (
	input wire clk,
	input wire reset,
	input wire phase_t phase,
	input wire [PIXEL_ROWS-1:0] row_select,
	input wire row_strobe,
	input wire frame_done,
	input wire convert,
	input wire expose
);

	int fail_count = 0;

	row_select_onehot: assert property (@(posedge clk) disable iff (reset)
		(phase == phase_read) |-> $onehot(row_select))
		else begin
			fail_count++;
			$error("row_select not one-hot in the read phase");
		end

	row_select_idle: assert property (@(posedge clk) disable iff (reset)
		(phase != phase_read) |-> (row_select == '0))
		else begin
			fail_count++;
			$error("row_select active outside the read phase");
		end

	frame_done_pulse: assert property (@(posedge clk) disable iff (reset)
		frame_done |=> !frame_done)
		else begin
			fail_count++;
			$error("frame_done longer than one cycle");
		end

	strobe_in_read: assert property (@(posedge clk) disable iff (reset)
		row_strobe |-> (phase == phase_read))
		else begin
			fail_count++;
			$error("row_strobe outside the read phase");
		end

	convert_expose_apart: assert property (@(posedge clk) disable iff (reset)
		!(convert && expose))
		else begin
			fail_count++;
			$error("convert and expose high together");
		end

endmodule

bind frame_sequencer image_sensor_chk #(
	.PIXEL_ROWS(PIXEL_ROWS)
) u_chk (
	.clk(clk),
	.reset(reset),
	.phase(phase),
	.row_select(row_select),
	.row_strobe(row_strobe),
	.frame_done(frame_done),
	.convert(convert),
	.expose(expose)
);

`default_nettype wire

//--- image_sensor_tb.sv
`timescale 1ns/100ps
`default_nettype none

module image_sensor_tb import sensor_pkg::*, phase_pkg::*; ();

	localparam int PIXEL_COLS = 24;
	localparam int PIXEL_ROWS = 3;
	localparam int BUS_PIXELS = 8;
	localparam int NUM_PIXELS = PIXEL_COLS * PIXEL_ROWS;
	localparam int BEATS = PIXEL_COLS / BUS_PIXELS;
	localparam int BEAT_W = BUS_PIXELS * PIXEL_BITS;
	localparam int PRE_READ = 1 + DEFAULT_ERASE_CYCLES + DEFAULT_EXPOSE_CYCLES + RAMP_STEPS;
	localparam int FRAME_LEN = PRE_READ + PIXEL_ROWS * DEFAULT_ROW_READ_CYCLES;
	localparam int TIMEOUT = 2 * FRAME_LEN;
	localparam int RANDOM_FRAMES = 4;

	logic clk;
	logic reset;
	logic [NUM_PIXELS*PIXEL_BITS-1:0] light;
	wire [BEAT_W-1:0] data_out;
	wire out_valid;
	wire frame_done;

	integer seed;
	int mismatch_count;
	int other_count;
	bit timed_out;
	pixel_t light_pix [NUM_PIXELS];
	logic [BEAT_W-1:0] expected_q [$];

	image_sensor UUT (
		.clk(clk),
		.reset(reset),
		.light(light),
		.data_out(data_out),
		.out_valid(out_valid),
		.frame_done(frame_done)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic random_light();
		for (int i = 0; i < NUM_PIXELS; i++) begin
			light_pix[i] = pixel_t'($random(seed));
		end
	endtask

	task automatic apply_light();
		for (int i = 0; i < NUM_PIXELS; i++) begin
			light[i*PIXEL_BITS +: PIXEL_BITS] = light_pix[i];
		end
	endtask

	// Rows in order, lowest column in the low byte of each beat.
	task automatic build_model();
		logic [BEAT_W-1:0] beat;
		int col;
		expected_q.delete();
		for (int r = 0; r < PIXEL_ROWS; r++) begin
			for (int k = 0; k < BEATS; k++) begin
				beat = '0;
				for (int p = 0; p < BUS_PIXELS; p++) begin
					col = k * BUS_PIXELS + p;
					beat[p*PIXEL_BITS +: PIXEL_BITS] = 8'd255 - light_pix[r*PIXEL_COLS + col];
				end
				expected_q.push_back(beat);
			end
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic hold_reset();
		repeat (3) begin
			@(posedge clk);
			#2;
			if (out_valid || frame_done) begin
				$display("Error: out_valid or frame_done high while reset is asserted");
				other_count++;
			end
		end
		reset = 1'b0;
	endtask

	// Starts in the idle cycle and ends in the idle cycle of the next frame.
	task automatic run_frame(input string name);
		int idx;
		int valid_count;
		int run_len;
		logic [BEAT_W-1:0] expected;
		bit done;
		if (timed_out) return;
		apply_light();
		build_model();
		idx = 0;
		valid_count = 0;
		run_len = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			if ((out_valid || frame_done) && idx < PRE_READ) begin
				$display("Error in %s: output active at cycle %0d before the read phase", name, idx);
				other_count++;
			end
			if (out_valid) begin
				valid_count++;
				run_len++;
				if (expected_q.size() == 0) begin
					$display("Error in %s: beat arrived with no expected beat left", name);
					other_count++;
				end else begin
					expected = expected_q.pop_front();
					if (data_out !== expected) begin
						$display("Mismatch in %s: expected %h, actual %h", name, expected, data_out);
						mismatch_count++;
					end
				end
			end else begin
				if (data_out !== '0) begin
					$display("Error in %s: data_out not zero while out_valid is low", name);
					other_count++;
				end
				if (run_len != 0) begin
					check_count({name, " run length"}, BEATS, run_len);
					run_len = 0;
				end
			end
			if (frame_done) begin
				done = 1'b1;
				check_count({name, " run length"}, BEATS, run_len);
				check_count({name, " frame length"}, FRAME_LEN, idx + 1);
				check_count({name, " beat count"}, PIXEL_ROWS * BEATS, valid_count);
			end else if (idx == TIMEOUT) begin
				$display("Timeout in %s: no frame_done within %0d cycles", name, TIMEOUT);
				timed_out = 1'b1;
			end else begin
				@(posedge clk);
				#2;
				idx++;
			end
		end
		if (!timed_out) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Reset lands halfway through the ramp sweep.
	task automatic reset_in_convert();
		if (timed_out) return;
		random_light();
		apply_light();
		repeat (PRE_READ - RAMP_STEPS / 2) begin
			@(posedge clk);
			#2;
		end
		reset = 1'b1;
		#1;
		if (out_valid || frame_done) begin
			$display("Error: outputs not cleared when reset asserted in the convert phase");
			other_count++;
		end
		hold_reset();
	endtask

	initial begin
		seed = 32'h8768e8d4;
		mismatch_count = 0;
		other_count = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < NUM_PIXELS; i++) begin
			light_pix[i] = '0;
		end
		apply_light();
		hold_reset();
		for (int f = 0; f < RANDOM_FRAMES; f++) begin
			random_light();
			run_frame("random_frame");
		end
		for (int i = 0; i < NUM_PIXELS; i++) begin
			light_pix[i] = i[0] ? 8'd255 : 8'd0; // Alternating extremes.
		end
		run_frame("extreme_frame");
		reset_in_convert();
		random_light();
		run_frame("after_reset_frame");
		$display("Errors: %0d mismatches, %0d other, %0d assertion failures, timeout %0d",
			mismatch_count, other_count, UUT.u_sequencer.u_chk.fail_count, timed_out);
		if (timed_out || mismatch_count != 0 || other_count != 0
				|| UUT.u_sequencer.u_chk.fail_count != 0) begin
			$display("Simulation failed");
		end else begin
			$display("Simulation completed successfully");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
sensor_pkg.sv
phase_pkg.sv
frame_sequencer.sv
pixel_cell.sv
pixel_array.sv
row_serializer.sv
image_sensor.sv
image_sensor_chk.sv
image_sensor_tb.sv

//--- Bender.yml
package:
  name: image_sensor

sources:
  - sensor_pkg.sv
  - phase_pkg.sv
  - frame_sequencer.sv
  - pixel_cell.sv
  - pixel_array.sv
  - row_serializer.sv
  - image_sensor.sv
  - target: test
    files:
      - image_sensor_chk.sv
      - image_sensor_tb.sv
